// ==== design/rv_decode_consts.svh ====
// rv64i decode constants
`ifndef RV_DECODE_CONSTS_SVH
`define RV_DECODE_CONSTS_SVH

// data and pc width
`define RV_XLEN 64

// fetched instruction width
`define RV_INST_WD 32

// general register file geometry
`define RV_GPR_ADDR_WD 5
`define RV_GPR_NUM 32

// full ebreak encoding, system opcode with imm 1
`define RV_EBREAK_INST 32'h0010_0073

`endif

// ==== design/rv_decode_pkg.sv ====
// rv64i decode types
package rv_decode_pkg;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OPC_LOAD      = 7'b0000011,
    OPC_OP_IMM    = 7'b0010011,
    OPC_AUIPC     = 7'b0010111,
    OPC_OP_IMM_32 = 7'b0011011,
    OPC_STORE     = 7'b0100011,
    OPC_OP        = 7'b0110011,
    OPC_LUI       = 7'b0110111,
    OPC_OP_32     = 7'b0111011,
    OPC_BRANCH    = 7'b1100011,
    OPC_JALR      = 7'b1100111,
    OPC_JAL       = 7'b1101111,
    OPC_SYSTEM    = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
    ALU_COPY2  // passes operand 2, lui
  } alu_op_e;

  typedef enum logic [3:0] {
    BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU, BR_JAL, BR_JALR
  } br_func_e;

  // same encoding as funct3 of loads and stores
  typedef enum logic [2:0] {
    MEM_B  = 3'b000,
    MEM_H  = 3'b001,
    MEM_W  = 3'b010,
    MEM_D  = 3'b011,
    MEM_BU = 3'b100,
    MEM_HU = 3'b101,
    MEM_WU = 3'b110
  } mem_op_e;

  typedef enum logic {SRC1_RS1, SRC1_PC} src1_sel_e;

  typedef enum logic [1:0] {SRC2_RS2, SRC2_IMM, SRC2_FOUR} src2_sel_e;

endpackage

// ==== design/decode_if.sv ====
// decoded instruction fields
`timescale 1ns/1ps
`include "rv_decode_consts.svh"

interface decode_if;
  logic [`RV_GPR_ADDR_WD-1:0] rs1;
  logic [`RV_GPR_ADDR_WD-1:0] rs2;
  logic [`RV_GPR_ADDR_WD-1:0] rd;
  logic [`RV_XLEN-1:0]        imm;       // sign extended
  logic                       rs1_used;
  logic                       rs2_used;
  rv_decode_pkg::br_func_e    br_func;
  rv_decode_pkg::alu_op_e     alu_op;
  rv_decode_pkg::src1_sel_e   src1_sel;
  rv_decode_pkg::src2_sel_e   src2_sel;
  logic                       word_op;   // *w ops, 32-bit result
  logic                       gpr_wen;
  logic                       mem_ren;
  logic                       mem_wen;
  rv_decode_pkg::mem_op_e     mem_op;
  logic                       ebreak;
  logic                       invalid;

  modport decoder (
    output rs1, rs2, rd, imm, rs1_used, rs2_used, br_func, alu_op, src1_sel,
           src2_sel, word_op, gpr_wen, mem_ren, mem_wen, mem_op, ebreak, invalid
  );

  modport branch (input imm, br_func);

  modport stage (
    input rs1, rs2, rd, imm, rs1_used, rs2_used, br_func, alu_op, src1_sel,
          src2_sel, word_op, gpr_wen, mem_ren, mem_wen, mem_op, ebreak, invalid
  );
endinterface

// ==== design/inst_decoder.sv ====
// rv64i instruction decoder
`timescale 1ns/1ps
`include "rv_decode_consts.svh"

module inst_decoder (
  input  logic [`RV_INST_WD-1:0] i_inst,
  decode_if.decoder              dec
);

  rv_decode_pkg::opcode_e   opcode;
  logic [2:0]               funct3;
  logic [6:0]               funct7;
  logic                     f7_zero, f7_alt;
  logic                     f6_zero, f6_alt;   // rv64 shift-imm upper bits
  logic [`RV_XLEN-1:0]      imm_i, imm_s, imm_b, imm_u, imm_j;

  logic [`RV_XLEN-1:0]      imm;
  logic                     rs1_used, rs2_used;
  rv_decode_pkg::br_func_e  br_func;
  rv_decode_pkg::alu_op_e   alu_op;
  rv_decode_pkg::src1_sel_e src1_sel;
  rv_decode_pkg::src2_sel_e src2_sel;
  logic                     word_op, gpr_wen, mem_ren, mem_wen, ebreak, illegal;
  rv_decode_pkg::mem_op_e   mem_op;

  function automatic rv_decode_pkg::alu_op_e f3_to_alu(input logic [2:0] f3, input logic alt);
    rv_decode_pkg::alu_op_e op;
    case (f3)
      3'b000:  op = alt ? rv_decode_pkg::ALU_SUB : rv_decode_pkg::ALU_ADD;
      3'b001:  op = rv_decode_pkg::ALU_SLL;
      3'b010:  op = rv_decode_pkg::ALU_SLT;
      3'b011:  op = rv_decode_pkg::ALU_SLTU;
      3'b100:  op = rv_decode_pkg::ALU_XOR;
      3'b101:  op = alt ? rv_decode_pkg::ALU_SRA : rv_decode_pkg::ALU_SRL;
      3'b110:  op = rv_decode_pkg::ALU_OR;
      default: op = rv_decode_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode  = rv_decode_pkg::opcode_e'(i_inst[6:0]);
  assign funct3  = i_inst[14:12];
  assign funct7  = i_inst[31:25];
  assign f7_zero = funct7 == 7'b0000000;
  assign f7_alt  = funct7 == 7'b0100000;
  assign f6_zero = i_inst[31:26] == 6'b000000;
  assign f6_alt  = i_inst[31:26] == 6'b010000;

  assign imm_i = {{(`RV_XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(`RV_XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(`RV_XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};
  assign imm_u = {{(`RV_XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(`RV_XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  always_comb begin
    imm      = '0;
    rs1_used = 1'b0;
    rs2_used = 1'b0;
    br_func  = rv_decode_pkg::BR_NONE;
    alu_op   = rv_decode_pkg::ALU_ADD;
    src1_sel = rv_decode_pkg::SRC1_RS1;
    src2_sel = rv_decode_pkg::SRC2_RS2;
    word_op  = 1'b0;
    gpr_wen  = 1'b0;
    mem_ren  = 1'b0;
    mem_wen  = 1'b0;
    mem_op   = rv_decode_pkg::MEM_B;
    ebreak   = 1'b0;
    illegal  = 1'b0;
    case (opcode)
      rv_decode_pkg::OPC_LUI: begin
        imm      = imm_u;
        alu_op   = rv_decode_pkg::ALU_COPY2;
        src2_sel = rv_decode_pkg::SRC2_IMM;
        gpr_wen  = 1'b1;
      end
      rv_decode_pkg::OPC_AUIPC: begin
        imm      = imm_u;
        src1_sel = rv_decode_pkg::SRC1_PC;
        src2_sel = rv_decode_pkg::SRC2_IMM;
        gpr_wen  = 1'b1;
      end
      rv_decode_pkg::OPC_JAL: begin
        imm      = imm_j;
        br_func  = rv_decode_pkg::BR_JAL;
        src1_sel = rv_decode_pkg::SRC1_PC;     // link = pc + 4
        src2_sel = rv_decode_pkg::SRC2_FOUR;
        gpr_wen  = 1'b1;
      end
      rv_decode_pkg::OPC_JALR: begin
        imm      = imm_i;
        rs1_used = 1'b1;
        br_func  = rv_decode_pkg::BR_JALR;
        src1_sel = rv_decode_pkg::SRC1_PC;
        src2_sel = rv_decode_pkg::SRC2_FOUR;
        gpr_wen  = 1'b1;
        illegal  = funct3 != 3'b000;
      end
      rv_decode_pkg::OPC_BRANCH: begin
        imm      = imm_b;
        rs1_used = 1'b1;
        rs2_used = 1'b1;
        case (funct3)
          3'b000:  br_func = rv_decode_pkg::BR_BEQ;
          3'b001:  br_func = rv_decode_pkg::BR_BNE;
          3'b100:  br_func = rv_decode_pkg::BR_BLT;
          3'b101:  br_func = rv_decode_pkg::BR_BGE;
          3'b110:  br_func = rv_decode_pkg::BR_BLTU;
          3'b111:  br_func = rv_decode_pkg::BR_BGEU;
          default: illegal = 1'b1;
        endcase
      end
      rv_decode_pkg::OPC_LOAD: begin
        imm      = imm_i;
        rs1_used = 1'b1;
        src2_sel = rv_decode_pkg::SRC2_IMM;    // address = rs1 + imm
        mem_ren  = 1'b1;
        gpr_wen  = 1'b1;
        if (funct3 == 3'b111) illegal = 1'b1;
        else mem_op = rv_decode_pkg::mem_op_e'(funct3);
      end
      rv_decode_pkg::OPC_STORE: begin
        imm      = imm_s;
        rs1_used = 1'b1;
        rs2_used = 1'b1;                       // store data
        src2_sel = rv_decode_pkg::SRC2_IMM;
        mem_wen  = 1'b1;
        if (funct3[2]) illegal = 1'b1;
        else mem_op = rv_decode_pkg::mem_op_e'(funct3);
      end
      rv_decode_pkg::OPC_OP_IMM: begin
        imm      = imm_i;
        rs1_used = 1'b1;
        src2_sel = rv_decode_pkg::SRC2_IMM;
        alu_op   = f3_to_alu(funct3, funct3 == 3'b101 && i_inst[30]);
        gpr_wen  = 1'b1;
        if (funct3 == 3'b001) illegal = !f6_zero;
        if (funct3 == 3'b101) illegal = !(f6_zero || f6_alt);
      end
      rv_decode_pkg::OPC_OP: begin
        rs1_used = 1'b1;
        rs2_used = 1'b1;
        alu_op   = f3_to_alu(funct3, f7_alt);
        gpr_wen  = 1'b1;
        illegal  = !(f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
      end
      rv_decode_pkg::OPC_OP_IMM_32: begin
        imm      = imm_i;
        rs1_used = 1'b1;
        src2_sel = rv_decode_pkg::SRC2_IMM;
        alu_op   = f3_to_alu(funct3, funct3 == 3'b101 && f7_alt);
        word_op  = 1'b1;
        gpr_wen  = 1'b1;
        case (funct3)
          3'b000:  illegal = 1'b0;
          3'b001:  illegal = !f7_zero;
          3'b101:  illegal = !(f7_zero || f7_alt);
          default: illegal = 1'b1;
        endcase
      end
      rv_decode_pkg::OPC_OP_32: begin
        rs1_used = 1'b1;
        rs2_used = 1'b1;
        alu_op   = f3_to_alu(funct3, f7_alt);
        word_op  = 1'b1;
        gpr_wen  = 1'b1;
        case (funct3)
          3'b000, 3'b101: illegal = !(f7_zero || f7_alt);
          3'b001:         illegal = !f7_zero;
          default:        illegal = 1'b1;
        endcase
      end
      rv_decode_pkg::OPC_SYSTEM: begin
        ebreak  = i_inst == `RV_EBREAK_INST;
        illegal = !ebreak;                     // no csr, ecall, mret here
      end
      default: illegal = 1'b1;
    endcase
  end

  assign dec.rs1      = i_inst[19:15];
  assign dec.rs2      = i_inst[24:20];
  assign dec.rd       = i_inst[11:7];
  assign dec.imm      = imm;
  assign dec.rs1_used = rs1_used;
  assign dec.rs2_used = rs2_used;
  assign dec.alu_op   = alu_op;
  assign dec.src1_sel = src1_sel;
  assign dec.src2_sel = src2_sel;
  assign dec.word_op  = word_op;
  assign dec.mem_op   = mem_op;
  assign dec.ebreak   = ebreak;
  assign dec.invalid  = illegal;
  // illegal encodings must not change any architectural state
  assign dec.gpr_wen  = gpr_wen && !illegal;
  assign dec.mem_ren  = mem_ren && !illegal;
  assign dec.mem_wen  = mem_wen && !illegal;
  assign dec.br_func  = illegal ? rv_decode_pkg::BR_NONE : br_func;

endmodule

// ==== design/gpr_file.sv ====
// general register file
`timescale 1ns/1ps
`include "rv_decode_consts.svh"

module gpr_file (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  // read ports
  input  logic [`RV_GPR_ADDR_WD-1:0] i_raddr1,
  output logic [`RV_XLEN-1:0]        o_rdata1,
  input  logic [`RV_GPR_ADDR_WD-1:0] i_raddr2,
  output logic [`RV_XLEN-1:0]        o_rdata2,
  // write port
  input  logic                       i_wen,
  input  logic [`RV_GPR_ADDR_WD-1:0] i_waddr,
  input  logic [`RV_XLEN-1:0]        i_wdata
);

  // x0 is not stored
  logic [`RV_XLEN-1:0] regs [1:`RV_GPR_NUM-1];

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 1; i < `RV_GPR_NUM; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && i_waddr != '0) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // no write bypass, new data is seen a cycle later
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

  a_waddr_known: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    i_wen |-> !$isunknown(i_waddr)
  ) else $error("write-back address has unknown bits");

endmodule

// ==== design/branch_unit.sv ====
// branch and jump resolution
`timescale 1ns/1ps
`include "rv_decode_consts.svh"

module branch_unit (
  input  logic                i_valid,      // stage can hand off this cycle
  input  logic [`RV_XLEN-1:0] i_pc,
  input  logic [`RV_XLEN-1:0] i_rs1_data,
  input  logic [`RV_XLEN-1:0] i_rs2_data,
  decode_if.branch            dec,
  output logic                o_br_taken,
  output logic [`RV_XLEN-1:0] o_br_target
);

  logic                eq, lt, ltu;
  logic                cond;
  logic [`RV_XLEN-1:0] jalr_sum;
  logic [`RV_XLEN-1:0] pc_sum;

  assign eq  = i_rs1_data == i_rs2_data;
  assign lt  = $signed(i_rs1_data) < $signed(i_rs2_data);
  assign ltu = i_rs1_data < i_rs2_data;

  always_comb begin
    case (dec.br_func)
      rv_decode_pkg::BR_BEQ:  cond = eq;
      rv_decode_pkg::BR_BNE:  cond = !eq;
      rv_decode_pkg::BR_BLT:  cond = lt;
      rv_decode_pkg::BR_BGE:  cond = !lt;
      rv_decode_pkg::BR_BLTU: cond = ltu;
      rv_decode_pkg::BR_BGEU: cond = !ltu;
      rv_decode_pkg::BR_JAL,
      rv_decode_pkg::BR_JALR: cond = 1'b1;
      default:                cond = 1'b0;
    endcase
  end

  assign pc_sum   = i_pc + dec.imm;
  assign jalr_sum = i_rs1_data + dec.imm;

  // jalr drops bit 0 of the sum
  assign o_br_target = (dec.br_func == rv_decode_pkg::BR_JALR) ?
                       {jalr_sum[`RV_XLEN-1:1], 1'b0} : pc_sum;

  assign o_br_taken = i_valid && cond;

endmodule

// ==== design/id_stage.sv ====
// rv64i instruction decode stage
`timescale 1ns/1ps
`include "rv_decode_consts.svh"

module id_stage (
  input  logic                       i_clk,
  input  logic                       i_rst_n,
  // from fetch
  input  logic                       i_fs_to_ds_valid,
  input  logic [`RV_INST_WD-1:0]     i_fs_inst,
  input  logic [`RV_XLEN-1:0]        i_fs_pc,
  output logic                       o_ds_allowin,
  // to execute
  input  logic                       i_es_allowin,
  output logic                       o_ds_to_es_valid,
  output logic [`RV_XLEN-1:0]        o_pc,
  output logic [`RV_XLEN-1:0]        o_rs1_data,
  output logic [`RV_XLEN-1:0]        o_rs2_data,
  output logic [`RV_XLEN-1:0]        o_imm,
  output rv_decode_pkg::alu_op_e     o_alu_op,
  output rv_decode_pkg::src1_sel_e   o_src1_sel,
  output rv_decode_pkg::src2_sel_e   o_src2_sel,
  output logic                       o_word_op,
  output logic [`RV_GPR_ADDR_WD-1:0] o_rd,
  output logic                       o_gpr_wen,
  output logic                       o_mem_ren,
  output logic                       o_mem_wen,
  output rv_decode_pkg::mem_op_e     o_mem_op,
  output logic                       o_ebreak,
  output logic                       o_invalid,
  // redirect to fetch
  output logic                       o_br_taken,
  output logic [`RV_XLEN-1:0]        o_br_target,
  // write-back port
  input  logic                       i_wb_wen,
  input  logic [`RV_GPR_ADDR_WD-1:0] i_wb_addr,
  input  logic [`RV_XLEN-1:0]        i_wb_data,
  // pending destinations of younger stages
  input  logic [`RV_GPR_ADDR_WD-1:0] i_es_rd,
  input  logic [`RV_GPR_ADDR_WD-1:0] i_ms_rd,
  input  logic [`RV_GPR_ADDR_WD-1:0] i_ws_rd
);

  logic                   ds_valid;
  logic                   ds_ready_go;
  logic [`RV_INST_WD-1:0] ds_inst;
  logic [`RV_XLEN-1:0]    ds_pc;
  logic [`RV_XLEN-1:0]    rs1_data, rs2_data;
  logic                   es_hit, ms_hit, ws_hit;

  decode_if dec_bus ();

  // nonzero rd that a used source still waits on
  function automatic logic src_hit(
    input logic [`RV_GPR_ADDR_WD-1:0] rd,
    input logic [`RV_GPR_ADDR_WD-1:0] rs1,
    input logic [`RV_GPR_ADDR_WD-1:0] rs2,
    input logic                       rs1_used,
    input logic                       rs2_used
  );
    return (rd != '0) && ((rs1_used && rd == rs1) || (rs2_used && rd == rs2));
  endfunction

  assign es_hit = src_hit(i_es_rd, dec_bus.rs1, dec_bus.rs2, dec_bus.rs1_used, dec_bus.rs2_used);
  assign ms_hit = src_hit(i_ms_rd, dec_bus.rs1, dec_bus.rs2, dec_bus.rs1_used, dec_bus.rs2_used);
  assign ws_hit = src_hit(i_ws_rd, dec_bus.rs1, dec_bus.rs2, dec_bus.rs1_used, dec_bus.rs2_used);

  assign ds_ready_go      = !(es_hit || ms_hit || ws_hit);
  assign o_ds_allowin     = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ds_ready_go;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid && o_ds_allowin) begin
      ds_inst <= i_fs_inst;
      ds_pc   <= i_fs_pc;
    end
  end

  inst_decoder u_decoder (
    .i_inst (ds_inst),
    .dec    (dec_bus)
  );

  gpr_file u_gpr (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_raddr1 (dec_bus.rs1),
    .o_rdata1 (rs1_data),
    .i_raddr2 (dec_bus.rs2),
    .o_rdata2 (rs2_data),
    .i_wen    (i_wb_wen),
    .i_waddr  (i_wb_addr),
    .i_wdata  (i_wb_data)
  );

  branch_unit u_branch (
    .i_valid     (o_ds_to_es_valid),   // redirect only on a real handoff
    .i_pc        (ds_pc),
    .i_rs1_data  (rs1_data),
    .i_rs2_data  (rs2_data),
    .dec         (dec_bus),
    .o_br_taken  (o_br_taken),
    .o_br_target (o_br_target)
  );

  assign o_pc       = ds_pc;
  assign o_rs1_data = rs1_data;
  assign o_rs2_data = rs2_data;
  assign o_imm      = dec_bus.imm;
  assign o_alu_op   = dec_bus.alu_op;
  assign o_src1_sel = dec_bus.src1_sel;
  assign o_src2_sel = dec_bus.src2_sel;
  assign o_word_op  = dec_bus.word_op;
  assign o_rd       = dec_bus.rd;
  assign o_gpr_wen  = dec_bus.gpr_wen;
  assign o_mem_ren  = dec_bus.mem_ren;
  assign o_mem_wen  = dec_bus.mem_wen;
  assign o_mem_op   = dec_bus.mem_op;
  assign o_ebreak   = dec_bus.ebreak;
  assign o_invalid  = dec_bus.invalid;

  // held instruction must not move while execute is blocked
  a_hold_stable: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (o_ds_to_es_valid && !i_es_allowin) |=>
      o_ds_to_es_valid && $stable({o_pc, o_rs1_data, o_rs2_data, o_imm, o_rd, o_alu_op,
                                   o_gpr_wen, o_mem_wen, o_br_taken, o_br_target})
  ) else $error("decode outputs changed under back-pressure");

endmodule

// ==== bench/id_stage_tb.sv ====
// decode stage testbench
`timescale 1ns/1ps
`include "rv_decode_consts.svh"

module id_stage_tb;

  localparam int TEST_CYCLES    = 600;  // rough length of reset and all tests
  localparam int TIMEOUT_CYCLES = 5 * TEST_CYCLES;
  localparam int HANDOFF_WAIT   = 20;

  logic        i_clk = 1'b0;
  logic        i_rst_n, i_fs_to_ds_valid, i_es_allowin, i_wb_wen;
  logic [31:0] i_fs_inst;
  logic [63:0] i_fs_pc, i_wb_data;
  logic [4:0]  i_wb_addr, i_es_rd, i_ms_rd, i_ws_rd;
  logic        o_ds_allowin, o_ds_to_es_valid, o_word_op, o_gpr_wen, o_mem_ren, o_mem_wen;
  logic        o_ebreak, o_invalid, o_br_taken;
  logic [63:0] o_pc, o_rs1_data, o_rs2_data, o_imm, o_br_target;
  logic [4:0]  o_rd;
  rv_decode_pkg::alu_op_e   o_alu_op;
  rv_decode_pkg::src1_sel_e o_src1_sel;
  rv_decode_pkg::src2_sel_e o_src2_sel;
  rv_decode_pkg::mem_op_e   o_mem_op;

  logic [31:0] lcg_state = 32'h11f8;
  logic [63:0] gpr_model [32];
  int          cycles = 0;

  id_stage u_dut (.*);

  always #10 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("test failed");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  function automatic logic [63:0] rand64();
    logic [31:0] hi;
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    hi = lcg_state;
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {hi, lcg_state};
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  // b-type encoding with implied offset bit 0
  function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_decode_pkg::OPC_BRANCH};
  endfunction

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      $display("test failed");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic compare_ctrl(input string name, input rv_decode_pkg::alu_op_e alu,
      input rv_decode_pkg::src1_sel_e s1, input rv_decode_pkg::src2_sel_e s2,
      input logic word, input logic wen, input logic ren, input logic mwen);
    check({name, " alu_op"}, 64'(alu), 64'(o_alu_op));
    check({name, " src1_sel"}, 64'(s1), 64'(o_src1_sel));
    check({name, " src2_sel"}, 64'(s2), 64'(o_src2_sel));
    check({name, " word_op"}, 64'(word), 64'(o_word_op));
    check({name, " gpr_wen"}, 64'(wen), 64'(o_gpr_wen));
    check({name, " mem_ren"}, 64'(ren), 64'(o_mem_ren));
    check({name, " mem_wen"}, 64'(mwen), 64'(o_mem_wen));
  endtask

  task automatic write_gpr(input logic [4:0] addr, input logic [63:0] data);
    @(negedge i_clk);
    i_wb_wen  = 1'b1;
    i_wb_addr = addr;
    i_wb_data = data;
    if (addr != 5'd0) gpr_model[addr] = data;   // x0 stays zero
    @(negedge i_clk);
    i_wb_wen = 1'b0;
  endtask

  task automatic issue(input logic [31:0] inst, input logic [63:0] pc);
    @(negedge i_clk);
    i_fs_to_ds_valid = 1'b1;
    i_fs_inst        = inst;
    i_fs_pc          = pc;
    @(negedge i_clk);   // taken at the rising edge between
    i_fs_to_ds_valid = 1'b0;
  endtask

  task automatic hand_to_execute(input string name, input logic [31:0] inst,
      input logic [63:0] pc);
    int n;
    n = 0;
    issue(inst, pc);
    while (!o_ds_to_es_valid && n < HANDOFF_WAIT) begin
      @(negedge i_clk);
      n++;
    end
    if (!o_ds_to_es_valid) begin
      $display("%s was never handed to execute", name);
      $display("test failed");
      $fatal(1, "handoff wait expired");
    end
  endtask

  task automatic reset_and_x0();
    i_rst_n = 1'b0;
    repeat (4) @(negedge i_clk);
    check("reset valid", 64'd0, 64'(o_ds_to_es_valid));
    check("reset taken", 64'd0, 64'(o_br_taken));
    check("reset allowin", 64'd1, 64'(o_ds_allowin));
    repeat (12) @(negedge i_clk);
    i_rst_n = 1'b1;
    @(negedge i_clk);
    check("post reset valid", 64'd0, 64'(o_ds_to_es_valid));
    check("post reset taken", 64'd0, 64'(o_br_taken));
    check("post reset allowin", 64'd1, 64'(o_ds_allowin));
    write_gpr(5'd0, rand64());
    hand_to_execute("x0 read", r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd7, rv_decode_pkg::OPC_OP),
                    64'h1000);
    check("x0 rs1", 64'd0, o_rs1_data);
    check("x0 rs2", 64'd0, o_rs2_data);
  endtask

  task automatic alu_mem_decode();
    logic [63:0] a, b, pc;
    logic [11:0] imm;
    logic [19:0] up;
    logic [4:0]  sh;
    a   = rand64();
    b   = rand64();
    pc  = rand64() & ~64'h3;
    imm = 12'(rand64());
    up  = 20'(rand64());
    sh  = 5'(rand64());
    write_gpr(5'd5, a);
    write_gpr(5'd6, b);
    hand_to_execute("add", r_type(7'h00, 5'd6, 5'd5, 3'd0, 5'd7, rv_decode_pkg::OPC_OP), pc);
    check("add rs1", gpr_model[5], o_rs1_data);
    check("add rs2", gpr_model[6], o_rs2_data);
    check("add rd", 64'd7, 64'(o_rd));
    compare_ctrl("add", rv_decode_pkg::ALU_ADD, rv_decode_pkg::SRC1_RS1,
                 rv_decode_pkg::SRC2_RS2, 1'b0, 1'b1, 1'b0, 1'b0);
    hand_to_execute("sub", r_type(7'h20, 5'd6, 5'd5, 3'd0, 5'd7, rv_decode_pkg::OPC_OP),
                    pc + 4);
    compare_ctrl("sub", rv_decode_pkg::ALU_SUB, rv_decode_pkg::SRC1_RS1,
                 rv_decode_pkg::SRC2_RS2, 1'b0, 1'b1, 1'b0, 1'b0);
    hand_to_execute("addi", i_type(imm, 5'd5, 3'd0, 5'd8, rv_decode_pkg::OPC_OP_IMM), pc + 8);
    check("addi rs1", gpr_model[5], o_rs1_data);
    check("addi imm", {{52{imm[11]}}, imm}, o_imm);
    check("addi rd", 64'd8, 64'(o_rd));
    compare_ctrl("addi", rv_decode_pkg::ALU_ADD, rv_decode_pkg::SRC1_RS1,
                 rv_decode_pkg::SRC2_IMM, 1'b0, 1'b1, 1'b0, 1'b0);
    hand_to_execute("slliw", i_type({7'd0, sh}, 5'd6, 3'd1, 5'd9,
                    rv_decode_pkg::OPC_OP_IMM_32), pc);
    check("slliw rs1", gpr_model[6], o_rs1_data);
    check("slliw imm", {59'd0, sh}, o_imm);
    compare_ctrl("slliw", rv_decode_pkg::ALU_SLL, rv_decode_pkg::SRC1_RS1,
                 rv_decode_pkg::SRC2_IMM, 1'b1, 1'b1, 1'b0, 1'b0);
    hand_to_execute("lui", {up, 5'd10, rv_decode_pkg::OPC_LUI}, pc);
    check("lui imm", {{32{up[19]}}, up, 12'd0}, o_imm);
    check("lui rd", 64'd10, 64'(o_rd));
    compare_ctrl("lui", rv_decode_pkg::ALU_COPY2, rv_decode_pkg::SRC1_RS1,
                 rv_decode_pkg::SRC2_IMM, 1'b0, 1'b1, 1'b0, 1'b0);
    hand_to_execute("auipc", {up, 5'd11, rv_decode_pkg::OPC_AUIPC}, pc + 12);
    check("auipc pc", pc + 12, o_pc);
    check("auipc imm", {{32{up[19]}}, up, 12'd0}, o_imm);
    compare_ctrl("auipc", rv_decode_pkg::ALU_ADD, rv_decode_pkg::SRC1_PC,
                 rv_decode_pkg::SRC2_IMM, 1'b0, 1'b1, 1'b0, 1'b0);
    hand_to_execute("ld", i_type(imm, 5'd5, 3'd3, 5'd12, rv_decode_pkg::OPC_LOAD), pc);
    check("ld rs1", gpr_model[5], o_rs1_data);
    check("ld imm", {{52{imm[11]}}, imm}, o_imm);
    check("ld mem_op", 64'(rv_decode_pkg::MEM_D), 64'(o_mem_op));
    compare_ctrl("ld", rv_decode_pkg::ALU_ADD, rv_decode_pkg::SRC1_RS1,
                 rv_decode_pkg::SRC2_IMM, 1'b0, 1'b1, 1'b1, 1'b0);
    hand_to_execute("sd", {imm[11:5], 5'd6, 5'd5, 3'd3, imm[4:0], rv_decode_pkg::OPC_STORE}, pc);
    check("sd rs2", gpr_model[6], o_rs2_data);
    check("sd imm", {{52{imm[11]}}, imm}, o_imm);
    check("sd mem_op", 64'(rv_decode_pkg::MEM_D), 64'(o_mem_op));
    compare_ctrl("sd", rv_decode_pkg::ALU_ADD, rv_decode_pkg::SRC1_RS1,
                 rv_decode_pkg::SRC2_IMM, 1'b0, 1'b0, 1'b0, 1'b1);
  endtask

  task automatic branch_case(input string name, input logic [31:0] inst, input logic [63:0] pc,
      input logic taken, input logic [63:0] target);
    hand_to_execute(name, inst, pc);
    check({name, " taken"}, 64'(taken), 64'(o_br_taken));
    check({name, " target"}, target, o_br_target);
  endtask

  task automatic branch_resolve();
    logic [63:0] a, b, c, pc;
    logic [12:0] fwd, back;
    logic [20:0] joff;
    logic [11:0] imm;
    a    = 64'hffff_ffff_ffff_fffb;   // -5 and huge as unsigned
    b    = 64'd3;
    c    = rand64();
    pc   = rand64() & ~64'h3;
    fwd  = 13'h01f0;
    back = 13'h1ff0;                  // -16
    joff = 21'(rand64() & 64'h0f_fffe);
    imm  = 12'(rand64());
    write_gpr(5'd13, a);
    write_gpr(5'd14, b);
    write_gpr(5'd15, c);
    // -5 vs 3 differ, signed less, unsigned not less
    branch_case("beq", b_type(fwd, 5'd14, 5'd13, 3'd0), pc, 1'b0, pc + {{51{1'b0}}, fwd});
    branch_case("bne", b_type(back, 5'd14, 5'd13, 3'd1), pc, 1'b1, pc - 64'd16);
    branch_case("blt", b_type(fwd, 5'd14, 5'd13, 3'd4), pc, 1'b1, pc + {{51{1'b0}}, fwd});
    branch_case("bgeu", b_type(back, 5'd14, 5'd13, 3'd7), pc, 1'b1, pc - 64'd16);
    branch_case("beq self", b_type(fwd, 5'd13, 5'd13, 3'd0), pc, 1'b1, pc + {{51{1'b0}}, fwd});
    branch_case("jal", {joff[20], joff[10:1], joff[11], joff[19:12], 5'd1,
                rv_decode_pkg::OPC_JAL}, pc, 1'b1, pc + {{43{joff[20]}}, joff});
    compare_ctrl("jal", rv_decode_pkg::ALU_ADD, rv_decode_pkg::SRC1_PC,
                 rv_decode_pkg::SRC2_FOUR, 1'b0, 1'b1, 1'b0, 1'b0);
    branch_case("jalr", i_type(imm, 5'd15, 3'd0, 5'd1, rv_decode_pkg::OPC_JALR), pc, 1'b1,
                (c + {{52{imm[11]}}, imm}) & ~64'd1);
  endtask

  task automatic hazard_stall();
    for (int s = 0; s < 3; s++) begin
      @(negedge i_clk);
      case (s)
        0:       i_es_rd = 5'd6;   // rs2 match
        1:       i_ms_rd = 5'd5;   // rs1 match
        default: i_ws_rd = 5'd6;
      endcase
      issue(r_type(7'h00, 5'd6, 5'd5, 3'd0, 5'd7, rv_decode_pkg::OPC_OP), 64'h2000);
      repeat (3) begin
        check($sformatf("hazard %0d valid", s), 64'd0, 64'(o_ds_to_es_valid));
        check($sformatf("hazard %0d allowin", s), 64'd0, 64'(o_ds_allowin));
        @(negedge i_clk);
      end
      i_es_rd      = 5'd0;
      i_ms_rd      = 5'd0;
      i_ws_rd      = 5'd0;
      i_es_allowin = 1'b0;   // keep the released instruction visible
      @(negedge i_clk);
      check($sformatf("hazard %0d release", s), 64'd1, 64'(o_ds_to_es_valid));
      i_es_allowin = 1'b1;
    end
    issue(r_type(7'h00, 5'd6, 5'd0, 3'd0, 5'd7, rv_decode_pkg::OPC_OP), 64'h2004);
    check("rd zero no stall", 64'd1, 64'(o_ds_to_es_valid));
    @(negedge i_clk);
    i_ws_rd = 5'd9;   // matches the addi rs2 field only
    issue(i_type(12'h009, 5'd5, 3'd0, 5'd8, rv_decode_pkg::OPC_OP_IMM), 64'h2008);
    check("unused rs2 no stall", 64'd1, 64'(o_ds_to_es_valid));
    i_ws_rd = 5'd0;
  endtask

  task automatic back_pressure();
    @(negedge i_clk);
    i_es_allowin = 1'b0;
    issue(r_type(7'h00, 5'd6, 5'd5, 3'd0, 5'd7, rv_decode_pkg::OPC_OP), 64'h3000);
    i_fs_to_ds_valid = 1'b1;
    i_fs_inst        = i_type(12'h010, 5'd6, 3'd0, 5'd8, rv_decode_pkg::OPC_OP_IMM);
    i_fs_pc          = 64'h3004;
    repeat (4) begin
      @(negedge i_clk);
      check("held valid", 64'd1, 64'(o_ds_to_es_valid));
      check("held allowin", 64'd0, 64'(o_ds_allowin));
      check("held pc", 64'h3000, o_pc);
      check("held rd", 64'd7, 64'(o_rd));
      check("held rs1", gpr_model[5], o_rs1_data);
    end
    i_es_allowin = 1'b1;
    @(negedge i_clk);
    i_fs_to_ds_valid = 1'b0;
    check("next pc", 64'h3004, o_pc);
    check("next rd", 64'd8, 64'(o_rd));
    check("next valid", 64'd1, 64'(o_ds_to_es_valid));
  endtask

  task automatic invalid_decode();
    logic [63:0] r;
    r = rand64();
    hand_to_execute("ebreak", `RV_EBREAK_INST, 64'h4000);
    check("ebreak flag", 64'd1, 64'(o_ebreak));
    check("ebreak invalid", 64'd0, 64'(o_invalid));
    check("ebreak gpr_wen", 64'd0, 64'(o_gpr_wen));
    hand_to_execute("custom op", {r[24:0], 7'b0001011}, 64'h4004);
    check("custom invalid", 64'd1, 64'(o_invalid));
    check("custom gpr_wen", 64'd0, 64'(o_gpr_wen));
    check("custom mem_wen", 64'd0, 64'(o_mem_wen));
    check("custom mem_ren", 64'd0, 64'(o_mem_ren));
    check("custom taken", 64'd0, 64'(o_br_taken));
    hand_to_execute("bad slli", i_type({6'b010000, 6'd3}, 5'd5, 3'd1, 5'd7,
                    rv_decode_pkg::OPC_OP_IMM), 64'h4008);
    check("bad slli invalid", 64'd1, 64'(o_invalid));
    check("bad slli gpr_wen", 64'd0, 64'(o_gpr_wen));
    // jalr needs funct3 of zero
    hand_to_execute("bad jalr", i_type(12'h004, 5'd15, 3'd1, 5'd1, rv_decode_pkg::OPC_JALR),
                    64'h400c);
    check("bad jalr invalid", 64'd1, 64'(o_invalid));
    check("bad jalr taken", 64'd0, 64'(o_br_taken));
    check("bad jalr gpr_wen", 64'd0, 64'(o_gpr_wen));
    hand_to_execute("bad store", {7'd0, 5'd6, 5'd5, 3'd4, 5'd0, rv_decode_pkg::OPC_STORE},
                    64'h4010);
    check("bad store invalid", 64'd1, 64'(o_invalid));
    check("bad store mem_wen", 64'd0, 64'(o_mem_wen));
  endtask

  initial begin
    i_rst_n          = 1'b0;
    i_fs_to_ds_valid = 1'b0;
    i_fs_inst        = '0;
    i_fs_pc          = '0;
    i_es_allowin     = 1'b1;
    i_wb_wen         = 1'b0;
    i_wb_addr        = '0;
    i_wb_data        = '0;
    i_es_rd          = '0;
    i_ms_rd          = '0;
    i_ws_rd          = '0;
    foreach (gpr_model[i]) gpr_model[i] = '0;
    reset_and_x0();
    alu_mem_decode();
    branch_resolve();
    hazard_stall();
    back_pressure();
    invalid_decode();
    $display("test passed");
    $finish;
  end

endmodule

// ==== id_stage.f ====
+incdir+design
design/rv_decode_pkg.sv
design/decode_if.sv
design/inst_decoder.sv
design/gpr_file.sv
design/branch_unit.sv
design/id_stage.sv
bench/id_stage_tb.sv

// ==== Makefile ====
TOP = id_stage_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f id_stage.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f id_stage.f --top-module $(TOP) -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
